// File: Makefile
# verilator build and run of the load/store unit testbench
# every variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= lsu_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing -j $(JOBS)
PASS_TEXT ?= All checks passed

SIM = $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run, and look for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

$(SIM): $(FILELIST) hdl/*.sv hdl/*.svh testbench/*.sv
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM)
	@out=$$(./$(SIM)); echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// File: hdl/data_ram.sv
// data ram
// word-wide synchronous memory with one write enable per byte lane
// read data is registered and shows the old word during a write

`timescale 1ns/1ps

`include "lsu_defines.svh"

module data_ram (
	input  logic           clock,
	input  logic           en_i,
	input  logic           we_i,
	input  lsu_pkg::word_t addr_i,
	input  lsu_pkg::word_t wdata_i,
	input  logic [3:0]     strb_i,
	output lsu_pkg::word_t rdata_o
);

	localparam int IDX_W = $clog2(`LSU_RAM_WORDS);

	lsu_pkg::word_t mem [`LSU_RAM_WORDS];

	logic [IDX_W-1:0] idx;

	// word index, upper address bits dropped so the space wraps
	assign idx = addr_i[IDX_W+1:2];

	// byte-lane writes
	always_ff @(posedge clock) begin
		if (en_i && we_i) begin
			for (int lane = 0; lane < 4; lane++) begin
				if (strb_i[lane]) begin
					mem[idx][lane*8 +: 8] <= wdata_i[lane*8 +: 8];
				end
			end
		end
	end

	// registered read, old contents on a write
	always_ff @(posedge clock) begin
		if (en_i) begin
			rdata_o <= mem[idx];
		end
	end

endmodule

// File: hdl/lsu_defines.svh
// lsu defines
// global sizing constants for the load/store stage and its memory
// data path width, register index width, ram depth and wait states

`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// width of data and addresses in bits
`define LSU_DATA_W 32

// width of a destination register index
`define LSU_REG_W 5

// ram depth in 32-bit words
// address bits above the word index are dropped, so accesses wrap
`define LSU_RAM_WORDS 256

// idle cycles spent by the controller before every ram access
// zero is legal and gives the shortest access
`define LSU_WAIT_STATES 2

`endif

// File: hdl/lsu_load_extend.sv
// load extender
// moves the addressed byte or half of the read word down to bit 0
// and sign- or zero-extends it according to the load type

`timescale 1ns/1ps

module lsu_load_extend (
	input  lsu_pkg::lsu_op_e op_i,
	input  lsu_pkg::word_t   addr_i,
	input  lsu_pkg::word_t   ram_rdata_i,
	output lsu_pkg::word_t   load_data_o
);

	lsu_pkg::word_t shifted;

	// byte offset times eight
	assign shifted = ram_rdata_i >> {addr_i[1:0], 3'b000};

	always_comb begin
		case (op_i)
			lsu_pkg::OP_LB: begin
				load_data_o = {{24{shifted[7]}}, shifted[7:0]};
			end
			lsu_pkg::OP_LH: begin
				load_data_o = {{16{shifted[15]}}, shifted[15:0]};
			end
			lsu_pkg::OP_LBU: begin
				load_data_o = {24'h000000, shifted[7:0]};
			end
			lsu_pkg::OP_LHU: begin
				load_data_o = {16'h0000, shifted[15:0]};
			end
			default: begin
				// word load, offset is zero for aligned words
				load_data_o = shifted;
			end
		endcase
	end

endmodule

// File: hdl/lsu_pkg.sv
// lsu package
// shared types for the load/store stage, the aligners and the memory controller
// word and register index vectors, operation codes, controller states

`include "lsu_defines.svh"

package lsu_pkg;

	// addresses and data words
	typedef logic [`LSU_DATA_W-1:0] word_t;

	// destination register index
	typedef logic [`LSU_REG_W-1:0] reg_idx_t;

	// operation presented by the upstream stage
	typedef enum logic [3:0] {
		OP_ALU = 4'd0,
		// loads, signed then unsigned
		OP_LB  = 4'd1,
		OP_LH  = 4'd2,
		OP_LW  = 4'd3,
		OP_LBU = 4'd4,
		OP_LHU = 4'd5,
		// stores
		OP_SB  = 4'd6,
		OP_SH  = 4'd7,
		OP_SW  = 4'd8
	} lsu_op_e;

	// memory controller states
	typedef enum logic [1:0] {
		MEM_IDLE   = 2'd0,
		MEM_WAIT   = 2'd1,
		MEM_ACCESS = 2'd2
	} mem_state_e;

endpackage

// File: hdl/lsu_stage.sv
// load/store pipeline stage
// holds one operation between the upstream and write-back handshakes
// issues a select/write request for loads and stores and waits for completion
// picks the write-back value and its write flag

`timescale 1ns/1ps

module lsu_stage (
	input  logic               clock,
	input  logic               rstn,
	input  logic               in_valid_i,
	input  lsu_pkg::lsu_op_e   op_i,
	input  lsu_pkg::word_t     addr_i,
	input  lsu_pkg::word_t     wdata_i,
	input  lsu_pkg::reg_idx_t  rd_i,
	input  logic               wbu_allowin_i,
	input  logic               mem_done_i,
	input  lsu_pkg::word_t     load_data_i,
	output logic               lsu_allowin_o,
	output logic               wbu_valid_o,
	output logic               wd_o,
	output lsu_pkg::reg_idx_t  rd_o,
	output lsu_pkg::word_t     result_o,
	output logic               mem_sel_o,
	output logic               mem_write_o,
	output lsu_pkg::lsu_op_e   op_o,
	output lsu_pkg::word_t     addr_o,
	output lsu_pkg::word_t     store_data_o
);

	// control flags
	logic              valid_q;
	logic              done_q;
	// operation payload
	lsu_pkg::lsu_op_e  op_q;
	lsu_pkg::word_t    addr_q;
	lsu_pkg::word_t    wdata_q;
	lsu_pkg::reg_idx_t rd_q;
	// extended load word captured on completion
	lsu_pkg::word_t    rdata_q;

	logic is_load;
	logic is_store;
	logic ready_go;
	logic accept;

	// operation class decode
	assign is_load  = (op_q == lsu_pkg::OP_LB)  || (op_q == lsu_pkg::OP_LH) ||
	                  (op_q == lsu_pkg::OP_LW)  || (op_q == lsu_pkg::OP_LBU) ||
	                  (op_q == lsu_pkg::OP_LHU);
	assign is_store = (op_q == lsu_pkg::OP_SB) || (op_q == lsu_pkg::OP_SH) ||
	                  (op_q == lsu_pkg::OP_SW);

	// alu ops finish at once, memory ops once the controller has answered
	assign ready_go      = ~(is_load | is_store) | done_q;
	assign lsu_allowin_o = ~valid_q | (ready_go & wbu_allowin_i);
	assign wbu_valid_o   = valid_q & ready_go;
	assign accept        = in_valid_i & lsu_allowin_o;

	always_ff @(posedge clock) begin
		if (!rstn) begin
			valid_q <= 1'b0;
		end else if (lsu_allowin_o) begin
			valid_q <= in_valid_i;
		end
	end

	// done flag is cleared by a new operation and set by the completion pulse
	always_ff @(posedge clock) begin
		if (!rstn) begin
			done_q <= 1'b0;
		end else if (accept) begin
			done_q <= 1'b0;
		end else if (mem_done_i) begin
			done_q <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			op_q    <= op_i;
			addr_q  <= addr_i;
			wdata_q <= wdata_i;
			rd_q    <= rd_i;
		end
	end

	always_ff @(posedge clock) begin
		if (mem_done_i) begin
			rdata_q <= load_data_i;
		end
	end

	// request stays up from the first held cycle until completion
	assign mem_sel_o    = valid_q & (is_load | is_store) & ~done_q;
	assign mem_write_o  = valid_q & is_store;
	assign op_o         = op_q;
	assign addr_o       = addr_q;
	assign store_data_o = wdata_q;

	// write-back selection; stores return zero
	assign rd_o     = rd_q;
	assign result_o = is_load ? rdata_q :
	                  is_store ? '0 : addr_q;
	assign wd_o     = valid_q & (is_load | ((op_q == lsu_pkg::OP_ALU) && (rd_q != '0)));

endmodule

// File: hdl/lsu_store_align.sv
// store aligner
// copies store data onto every byte lane it may land in
// and builds the byte strobe from the access size and the low address bits

`timescale 1ns/1ps

module lsu_store_align (
	input  lsu_pkg::lsu_op_e op_i,
	input  lsu_pkg::word_t   addr_i,
	input  lsu_pkg::word_t   store_data_i,
	output lsu_pkg::word_t   ram_wdata_o,
	output logic [3:0]       ram_strb_o
);

	always_comb begin
		case (op_i)
			lsu_pkg::OP_SB: begin
				// low byte on all four lanes, one lane enabled
				ram_wdata_o = {4{store_data_i[7:0]}};
				ram_strb_o  = 4'b0001 << addr_i[1:0];
			end
			lsu_pkg::OP_SH: begin
				// low half on both halves, bit 0 of the address ignored
				ram_wdata_o = {2{store_data_i[15:0]}};
				ram_strb_o  = 4'b0011 << {addr_i[1], 1'b0};
			end
			lsu_pkg::OP_SW: begin
				ram_wdata_o = store_data_i;
				ram_strb_o  = 4'b1111;
			end
			default: begin
				// loads and alu ops never write
				ram_wdata_o = store_data_i;
				ram_strb_o  = 4'b0000;
			end
		endcase
	end

endmodule

// File: hdl/lsu_top.sv
// load/store unit top
// connects the pipeline stage to its store and load aligners
// and to the memory controller, wait timer and data ram

`timescale 1ns/1ps

module lsu_top (
	input  logic              clock,
	input  logic              rstn,
	input  logic              in_valid_i,
	input  lsu_pkg::lsu_op_e  op_i,
	input  lsu_pkg::word_t    addr_i,
	input  lsu_pkg::word_t    wdata_i,
	input  lsu_pkg::reg_idx_t rd_i,
	input  logic              wbu_allowin_i,
	output logic              lsu_allowin_o,
	output logic              wbu_valid_o,
	output logic              wd_o,
	output lsu_pkg::reg_idx_t rd_o,
	output lsu_pkg::word_t    result_o
);

	// stage to controller
	logic             mem_sel;
	logic             mem_write;
	logic             mem_done;
	// held operation fields
	lsu_pkg::lsu_op_e stage_op;
	lsu_pkg::word_t   stage_addr;
	lsu_pkg::word_t   store_data;
	// ram data path
	lsu_pkg::word_t   ram_wdata;
	logic [3:0]       ram_strb;
	lsu_pkg::word_t   ram_rdata;
	lsu_pkg::word_t   load_data;
	// controller side
	logic             timer_load;
	logic             timer_expired;
	logic             ram_en;
	logic             ram_we;

	lsu_stage i_lsu_stage (
		.clock         (clock),
		.rstn          (rstn),
		.in_valid_i    (in_valid_i),
		.op_i          (op_i),
		.addr_i        (addr_i),
		.wdata_i       (wdata_i),
		.rd_i          (rd_i),
		.wbu_allowin_i (wbu_allowin_i),
		.mem_done_i    (mem_done),
		.load_data_i   (load_data),
		.lsu_allowin_o (lsu_allowin_o),
		.wbu_valid_o   (wbu_valid_o),
		.wd_o          (wd_o),
		.rd_o          (rd_o),
		.result_o      (result_o),
		.mem_sel_o     (mem_sel),
		.mem_write_o   (mem_write),
		.op_o          (stage_op),
		.addr_o        (stage_addr),
		.store_data_o  (store_data)
	);

	lsu_store_align i_lsu_store_align (
		.op_i         (stage_op),
		.addr_i       (stage_addr),
		.store_data_i (store_data),
		.ram_wdata_o  (ram_wdata),
		.ram_strb_o   (ram_strb)
	);

	lsu_load_extend i_lsu_load_extend (
		.op_i        (stage_op),
		.addr_i      (stage_addr),
		.ram_rdata_i (ram_rdata),
		.load_data_o (load_data)
	);

	mem_ctrl i_mem_ctrl (
		.clock           (clock),
		.rstn            (rstn),
		.mem_sel_i       (mem_sel),
		.mem_write_i     (mem_write),
		.timer_expired_i (timer_expired),
		.timer_load_o    (timer_load),
		.ram_en_o        (ram_en),
		.ram_we_o        (ram_we),
		.mem_done_o      (mem_done)
	);

	wait_timer i_wait_timer (
		.clock     (clock),
		.rstn      (rstn),
		.load_i    (timer_load),
		.expired_o (timer_expired)
	);

	data_ram i_data_ram (
		.clock   (clock),
		.en_i    (ram_en),
		.we_i    (ram_we),
		.addr_i  (stage_addr),
		.wdata_i (ram_wdata),
		.strb_i  (ram_strb),
		.rdata_o (ram_rdata)
	);

endmodule

// File: hdl/mem_ctrl.sv
// memory controller
// sequences one request: wait states, a single ram access, a completion pulse
// the done pulse lines up with the registered ram read data

`timescale 1ns/1ps

module mem_ctrl (
	input  logic clock,
	input  logic rstn,
	input  logic mem_sel_i,
	input  logic mem_write_i,
	input  logic timer_expired_i,
	output logic timer_load_o,
	output logic ram_en_o,
	output logic ram_we_o,
	output logic mem_done_o
);

	lsu_pkg::mem_state_e state_q;
	lsu_pkg::mem_state_e state_d;

	logic start;

	// select is still high while the done pulse is out, so hold off one cycle
	assign start = (state_q == lsu_pkg::MEM_IDLE) & mem_sel_i & ~mem_done_o;

	always_comb begin
		state_d = state_q;
		case (state_q)
			lsu_pkg::MEM_IDLE: begin
				if (start) begin
					state_d = lsu_pkg::MEM_WAIT;
				end
			end
			lsu_pkg::MEM_WAIT: begin
				if (timer_expired_i) begin
					state_d = lsu_pkg::MEM_ACCESS;
				end
			end
			lsu_pkg::MEM_ACCESS: begin
				state_d = lsu_pkg::MEM_IDLE;
			end
			default: begin
				state_d = lsu_pkg::MEM_IDLE;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rstn) begin
			state_q    <= lsu_pkg::MEM_IDLE;
			mem_done_o <= 1'b0;
		end else begin
			state_q    <= state_d;
			// ram output is valid the cycle after the access
			mem_done_o <= (state_q == lsu_pkg::MEM_ACCESS);
		end
	end

	assign timer_load_o = start;
	assign ram_en_o     = (state_q == lsu_pkg::MEM_ACCESS);
	assign ram_we_o     = (state_q == lsu_pkg::MEM_ACCESS) & mem_write_i;

endmodule

// File: hdl/wait_timer.sv
// wait-state timer
// loadable down-counter that flags when the configured wait has run out
// stays quiet until loaded, so nothing fires out of reset

`timescale 1ns/1ps

`include "lsu_defines.svh"

module wait_timer (
	input  logic clock,
	input  logic rstn,
	input  logic load_i,
	output logic expired_o
);

	// wide enough for the wait count, at least one bit
	localparam int CNT_W = $clog2(`LSU_WAIT_STATES + 2);

	logic [CNT_W-1:0] count_q;
	logic             armed_q;

	always_ff @(posedge clock) begin
		if (!rstn) begin
			count_q <= '0;
			armed_q <= 1'b0;
		end else if (load_i) begin
			count_q <= CNT_W'(`LSU_WAIT_STATES);
			armed_q <= 1'b1;
		end else if (count_q != '0) begin
			count_q <= count_q - 1'b1;
		end else begin
			// expiry is reported once
			armed_q <= 1'b0;
		end
	end

	assign expired_o = armed_q & (count_q == '0);

endmodule

// File: testbench/lsu_tb.sv
// load/store unit testbench
// reads operations and expected write-back values from the test file,
// feeds them through the upstream handshake and checks every result
// while the write-back side applies random back-pressure

`timescale 1ns/1ps

`include "lsu_defines.svh"

module lsu_tb;

	localparam int    MAX_TESTS = 64;
	localparam string TEST_FILE = "testbench/lsu_tests.txt";

	logic              clock;
	logic              rstn;
	logic              in_valid_i;
	lsu_pkg::lsu_op_e  op_i;
	lsu_pkg::word_t    addr_i;
	lsu_pkg::word_t    wdata_i;
	lsu_pkg::reg_idx_t rd_i;
	logic              wbu_allowin_i;
	logic              lsu_allowin_o;
	logic              wbu_valid_o;
	logic              wd_o;
	lsu_pkg::reg_idx_t rd_o;
	lsu_pkg::word_t    result_o;

	// test table as read from the file
	string             test_name   [MAX_TESTS];
	lsu_pkg::lsu_op_e  test_op     [MAX_TESTS];
	lsu_pkg::word_t    test_addr   [MAX_TESTS];
	lsu_pkg::word_t    test_wdata  [MAX_TESTS];
	lsu_pkg::reg_idx_t test_rd     [MAX_TESTS];
	lsu_pkg::word_t    test_result [MAX_TESTS];
	logic              test_wd     [MAX_TESTS];

	int     num_tests    = 0;
	int     issue_idx    = 0;
	int     results_seen = 0;
	logic   tests_loaded = 1'b0;
	integer seed         = 32'h49bdb697;
	// indices of accepted operations, oldest first
	int     pending [$];

	lsu_top i_lsu_top (
		.clock         (clock),
		.rstn          (rstn),
		.in_valid_i    (in_valid_i),
		.op_i          (op_i),
		.addr_i        (addr_i),
		.wdata_i       (wdata_i),
		.rd_i          (rd_i),
		.wbu_allowin_i (wbu_allowin_i),
		.lsu_allowin_o (lsu_allowin_o),
		.wbu_valid_o   (wbu_valid_o),
		.wd_o          (wd_o),
		.rd_o          (rd_o),
		.result_o      (result_o)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	task automatic abort_run();
		$display("Checks failed");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic check_word(input string name, input string what,
			input lsu_pkg::word_t expected, input lsu_pkg::word_t actual);
		if (actual !== expected) begin
			$display("ERROR %s %s: expected %h, actual %h", name, what, expected, actual);
			abort_run();
		end
	endtask

	task automatic check_idx(input string name, input string what,
			input lsu_pkg::reg_idx_t expected, input lsu_pkg::reg_idx_t actual);
		if (actual !== expected) begin
			$display("ERROR %s %s: expected %0d, actual %0d", name, what, expected, actual);
			abort_run();
		end
	endtask

	task automatic check_flag(input string name, input string what,
			input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("ERROR %s %s: expected %b, actual %b", name, what, expected, actual);
			abort_run();
		end
	endtask

	function automatic lsu_pkg::lsu_op_e op_from_name(input string s, output logic known);
		lsu_pkg::lsu_op_e op;
		known = 1'b1;
		case (s)
			"alu": op = lsu_pkg::OP_ALU;
			"lb": op = lsu_pkg::OP_LB;
			"lh": op = lsu_pkg::OP_LH;
			"lw": op = lsu_pkg::OP_LW;
			"lbu": op = lsu_pkg::OP_LBU;
			"lhu": op = lsu_pkg::OP_LHU;
			"sb": op = lsu_pkg::OP_SB;
			"sh": op = lsu_pkg::OP_SH;
			"sw": op = lsu_pkg::OP_SW;
			default: begin
				op    = lsu_pkg::OP_ALU;
				known = 1'b0;
			end
		endcase
		return op;
	endfunction

	task automatic load_tests();
		int                fd;
		int                n;
		string             line;
		string             name;
		string             op_name;
		lsu_pkg::word_t    addr;
		lsu_pkg::word_t    wdata;
		lsu_pkg::word_t    result;
		lsu_pkg::reg_idx_t rd;
		logic              wd;
		logic              known;
		fd = $fopen(TEST_FILE, "r");
		if (fd == 0) begin
			$display("cannot open the test file %s", TEST_FILE);
			abort_run();
		end
		while ($fgets(line, fd) != 0) begin
			// comment lines start with a hash
			if (line.len() > 0 && line[0] != "#") begin
				n = $sscanf(line, "%s %s %h %h %d %h %d",
					name, op_name, addr, wdata, rd, result, wd);
				if (n == 7) begin
					if (num_tests == MAX_TESTS) begin
						$display("the test file holds more than %0d tests", MAX_TESTS);
						abort_run();
					end
					test_op[num_tests] = op_from_name(op_name, known);
					if (!known) begin
						$display("test %s has an unknown operation %s", name, op_name);
						abort_run();
					end
					test_name[num_tests]   = name;
					test_addr[num_tests]   = addr;
					test_wdata[num_tests]  = wdata;
					test_rd[num_tests]     = rd;
					test_result[num_tests] = result;
					test_wd[num_tests]     = wd;
					num_tests++;
				end else if (n > 0) begin
					$display("malformed line in the test file: %s", line);
					abort_run();
				end
			end
		end
		$fclose(fd);
		if (num_tests == 0) begin
			$display("the test file holds no tests");
			abort_run();
		end
	endtask

	// hold the current operation until accepted, then move to the next one
	task automatic present_next();
		if (issue_idx < num_tests) begin
			in_valid_i <= 1'b1;
			op_i       <= test_op[issue_idx];
			addr_i     <= test_addr[issue_idx];
			wdata_i    <= test_wdata[issue_idx];
			rd_i       <= test_rd[issue_idx];
		end else begin
			in_valid_i <= 1'b0;
		end
	endtask

	initial begin
		int                idx;
		logic              hold_active;
		string             held_name;
		lsu_pkg::word_t    held_result;
		lsu_pkg::reg_idx_t held_rd;
		logic              held_wd;
		hold_active   = 1'b0;
		rstn          <= 1'b0;
		in_valid_i    <= 1'b0;
		op_i          <= lsu_pkg::OP_ALU;
		addr_i        <= '0;
		wdata_i       <= '0;
		rd_i          <= '0;
		wbu_allowin_i <= 1'b0;
		load_tests();
		tests_loaded = 1'b1;
		repeat (2) @(posedge clock);
		// outputs after reset
		check_flag("reset", "wbu_valid_o", 1'b0, wbu_valid_o);
		check_flag("reset", "lsu_allowin_o", 1'b1, lsu_allowin_o);
		check_flag("reset", "wd_o", 1'b0, wd_o);
		rstn <= 1'b1;
		present_next();
		while (results_seen < num_tests) begin
			@(posedge clock);
			// a stalled result must not move
			if (hold_active) begin
				check_flag(held_name, "held wbu_valid_o", 1'b1, wbu_valid_o);
				check_word(held_name, "held result", held_result, result_o);
				check_idx(held_name, "held rd", held_rd, rd_o);
				check_flag(held_name, "held wd", held_wd, wd_o);
			end
			if (wbu_valid_o && wbu_allowin_i) begin
				if (pending.size() == 0) begin
					$display("a result left the stage with no operation pending");
					abort_run();
				end
				idx = pending.pop_front();
				check_word(test_name[idx], "result", test_result[idx], result_o);
				check_idx(test_name[idx], "rd", test_rd[idx], rd_o);
				check_flag(test_name[idx], "wd", test_wd[idx], wd_o);
				results_seen++;
				hold_active = 1'b0;
			end else if (wbu_valid_o) begin
				held_name   = (pending.size() > 0) ? test_name[pending[0]] : "unknown";
				held_result = result_o;
				held_rd     = rd_o;
				held_wd     = wd_o;
				hold_active = 1'b1;
				// upstream is blocked while the result waits
				check_flag(held_name, "stalled lsu_allowin_o", 1'b0, lsu_allowin_o);
			end else begin
				hold_active = 1'b0;
			end
			// upstream transfer at this edge
			if (in_valid_i && lsu_allowin_o) begin
				pending.push_back(issue_idx);
				issue_idx++;
			end
			present_next();
			// low about a third of the time
			wbu_allowin_i <= ($unsigned($random(seed)) % 3) != 0;
		end
		// the stage stays empty once the last result has left
		repeat (`LSU_WAIT_STATES + 6) begin
			@(posedge clock);
			check_flag("drain", "wbu_valid_o", 1'b0, wbu_valid_o);
			check_flag("drain", "lsu_allowin_o", 1'b1, lsu_allowin_o);
		end
		$display("All checks passed");
		$finish;
	end

	// watchdog sized from the number of tests
	initial begin
		int limit;
		wait (tests_loaded);
		limit = num_tests * (`LSU_WAIT_STATES + 6) * 4;
		repeat (limit) @(posedge clock);
		$display("timeout: results stopped arriving after %0d of %0d tests",
			results_seen, num_tests);
		abort_run();
	end

endmodule

// File: testbench/lsu_tests.txt
# name op addr wdata rd expected_result expected_wd
# addr, wdata and expected_result in hex; rd and expected_wd in decimal
alu_rd5     alu 12345678 00000000 5  12345678 1
alu_rd0     alu deadbeef 00000000 0  deadbeef 0
alu_rd31    alu 00000000 ffffffff 31 00000000 1
sw_10       sw  00000010 a1b2c3d4 1  00000000 0
lw_10       lw  00000010 00000000 2  a1b2c3d4 1
sw_20       sw  00000020 11223344 0  00000000 0
sb_20       sb  00000020 000000aa 3  00000000 0
sb_21       sb  00000021 ffffffbb 4  00000000 0
lw_20_a     lw  00000020 00000000 6  1122bbaa 1
sb_22       sb  00000022 000000cc 0  00000000 0
sb_23       sb  00000023 000000dd 0  00000000 0
lw_20_b     lw  00000020 00000000 7  ddccbbaa 1
lbu_21      lbu 00000021 00000000 8  000000bb 1
lb_21       lb  00000021 00000000 9  ffffffbb 1
lhu_22      lhu 00000022 00000000 10 0000ddcc 1
lh_22       lh  00000022 00000000 11 ffffddcc 1
sw_24       sw  00000024 55667788 0  00000000 0
sh_24       sh  00000024 0000beef 12 00000000 0
sh_26       sh  00000026 1234cafe 0  00000000 0
lw_24_a     lw  00000024 00000000 13 cafebeef 1
sh_25       sh  00000025 00001357 0  00000000 0
lw_24_b     lw  00000024 00000000 14 cafe1357 1
sw_30       sw  00000030 80ff7f01 0  00000000 0
lb_30       lb  00000030 00000000 15 00000001 1
lb_31       lb  00000031 00000000 16 0000007f 1
lb_32       lb  00000032 00000000 17 ffffffff 1
lb_33       lb  00000033 00000000 18 ffffff80 1
lbu_32      lbu 00000032 00000000 19 000000ff 1
lbu_33      lbu 00000033 00000000 20 00000080 1
lh_30       lh  00000030 00000000 21 00007f01 1
lh_32       lh  00000032 00000000 22 ffff80ff 1
lhu_30      lhu 00000030 00000000 23 00007f01 1
lhu_32      lhu 00000032 00000000 24 000080ff 1
sw_wrap     sw  00000440 0badf00d 25 00000000 0
lw_wrap     lw  00000040 00000000 26 0badf00d 1
lw_wrap_hi  lw  00010040 00000000 27 0badf00d 1
sw_top      sw  000003fc 76543210 0  00000000 0
lw_top_wrap lw  fffffffc 00000000 28 76543210 1
lw_10_rd0   lw  00000010 00000000 0  a1b2c3d4 1
alu_last    alu cafef00d 00000000 9  cafef00d 1

// File: verilog.f
+incdir+hdl
hdl/lsu_pkg.sv
hdl/lsu_stage.sv
hdl/lsu_store_align.sv
hdl/lsu_load_extend.sv
hdl/mem_ctrl.sv
hdl/wait_timer.sv
hdl/data_ram.sv
hdl/lsu_top.sv
testbench/lsu_tb.sv
